// ==== verilog/sync_pkg.sv ====
package sync_pkg;

    // raster position as it leaves the counter
    // widths follow vic_pkg::X_W and vic_pkg::Y_W
    typedef struct packed {
        logic [9:0] x;  // dot within the line
        logic [8:0] y;  // line within the frame
    } raster_pos_t;

    // per-chip sync timing, all in dots or lines
    typedef struct packed {
        logic [9:0] hsync_start;
        logic [9:0] hsync_end;       // last dot of hsync, inclusive
        logic [9:0] hvisible_start;
        logic [9:0] half_line;       // line_len / 2
        logic [8:0] vblank_start;    // first of the nine vertical sync lines
        logic [8:0] vblank_end;
        logic [5:0] eq_width;        // equalization pulse, dots
        logic [5:0] serr_width;      // serration gap, dots
    } sync_timing_t;

endpackage

// ==== verilog/vic_pkg.sv ====
package vic_pkg;

    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6567R56A = 2'd1,
        CHIP6569     = 2'd2,
        CHIPUNUSED   = 2'd3
    } chip_t;

    localparam int X_W = 10;
    localparam int Y_W = 9;

    // dots per raster line
    function automatic logic [X_W-1:0] line_len(input chip_t chip);
        case (chip)
            CHIP6567R8:   line_len = 10'd520;
            CHIP6567R56A: line_len = 10'd512;
            default:      line_len = 10'd504;  // 6569, unused code too
        endcase
    endfunction

    // lines per frame
    function automatic logic [Y_W-1:0] frame_lines(input chip_t chip);
        case (chip)
            CHIP6567R8:   frame_lines = 9'd263;
            CHIP6567R56A: frame_lines = 9'd262;
            default:      frame_lines = 9'd312;
        endcase
    endfunction

    function automatic sync_pkg::sync_timing_t sync_timing(input chip_t chip);
        sync_pkg::sync_timing_t t;
        logic [X_W-1:0] len;

        len = line_len(chip);
        t.half_line  = len >> 1;
        t.eq_width   = 6'd18;
        t.serr_width = 6'd37;
        if (chip == CHIP6567R8 || chip == CHIP6567R56A)
        begin
            t.hsync_start    = 10'd409;
            t.hsync_end      = 10'd446;  // about 4.6us
            t.hvisible_start = 10'd497;
            t.vblank_start   = 9'd14;
            t.vblank_end     = 9'd22;
        end
        else
        begin
            // PAL
            t.hsync_start    = 10'd408;
            t.hsync_end      = 10'd444;
            t.hvisible_start = 10'd492;
            t.vblank_start   = 9'd301;
            t.vblank_end     = 9'd309;
        end
        return t;
    endfunction

endpackage

// ==== verilog/raster_counter.sv ====
module raster_counter #(
    parameter int DOT_DIV = 4   // clk_dot4x cycles per dot, 1 to 8
) (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  vic_pkg::chip_t        chip,
    output sync_pkg::raster_pos_t raster
);

    localparam int PRE_W = (DOT_DIV > 1) ? $clog2(DOT_DIV) : 1;

    logic [PRE_W-1:0]        pre_cnt;
    logic                    dot_tick;
    vic_pkg::chip_t          chip_q;
    logic [vic_pkg::X_W-1:0] x_last;
    logic [vic_pkg::Y_W-1:0] y_last;

    // one strobe per raster dot
    assign dot_tick = (pre_cnt == PRE_W'(DOT_DIV - 1));

    assign x_last = vic_pkg::line_len(chip_q) - 1'b1;
    assign y_last = vic_pkg::frame_lines(chip_q) - 1'b1;

    // chip model only taken while in reset
    always_ff @(posedge clk_dot4x)
    begin
        if (rst)
            chip_q <= chip;
    end

    always_ff @(posedge clk_dot4x)
    begin
        if (rst || dot_tick)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    always_ff @(posedge clk_dot4x)
    begin
        if (rst)
        begin
            raster <= '0;
        end
        else if (dot_tick)
        begin
            if (raster.x == x_last)
            begin
                raster.x <= '0;
                if (raster.y == y_last)
                    raster.y <= '0;  // frame wrap
                else
                    raster.y <= raster.y + 1'b1;
            end
            else
            begin
                raster.x <= raster.x + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/eq_serr_pulse.sv ====
module eq_serr_pulse (
    input  sync_pkg::raster_pos_t  raster,
    input  sync_pkg::sync_timing_t timing,
    output logic                   eq,
    output logic                   se
);

    // both pulse trains repeat every half line, starting at hsync_start
    logic [vic_pkg::X_W:0]   line_len;
    logic [vic_pkg::X_W:0]   ofs;       // dots since hsync_start, mod line_len
    logic [vic_pkg::X_W:0]   ofs_half;  // same, mod half_line
    logic [vic_pkg::X_W-1:0] se_len;

    assign line_len = {timing.half_line, 1'b0};

    always_comb
    begin
        if (raster.x >= timing.hsync_start)
            ofs = {1'b0, raster.x} - {1'b0, timing.hsync_start};
        else
            ofs = {1'b0, raster.x} + line_len - {1'b0, timing.hsync_start};  // wrapped
    end

    // second window begins half a line later
    always_comb
    begin
        if (ofs >= {1'b0, timing.half_line})
            ofs_half = ofs - {1'b0, timing.half_line};
        else
            ofs_half = ofs;
    end

    // serration is the half line minus its gap
    assign se_len = timing.half_line - {4'd0, timing.serr_width};

    assign eq = (ofs_half < {5'd0, timing.eq_width});
    assign se = (ofs_half < {1'b0, se_len});

endmodule

// ==== verilog/comp_sync.sv ====
module comp_sync (
    input  logic                   clk_dot4x,
    input  logic                   clk_col4x,
    input  logic                   rst,
    input  sync_pkg::raster_pos_t  raster,
    input  sync_pkg::sync_timing_t timing,
    input  logic                   eq,
    input  logic                   se,
    output logic                   csync,
    output logic                   composite_active,
    output logic                   clk_colref
);

    logic                    hsync;
    logic                    hsync_next;
    logic                    csync_next;
    logic [vic_pkg::Y_W-1:0] line_ofs;   // line offset into vertical sync
    logic                    in_vsync;
    logic [1:0]              col_div;

    assign hsync_next = (raster.x >= timing.hsync_start) &&
                        (raster.x <= timing.hsync_end);

    assign line_ofs = raster.y - timing.vblank_start;
    assign in_vsync = (raster.y >= timing.vblank_start) && (line_ofs < 9);

    // nine lines: 3 equalizing, 3 serrated, 3 equalizing
    always_comb
    begin
        if (!in_vsync)
            csync_next = ~hsync_next;
        else
        begin
            case (line_ofs)
                9'd3, 9'd4, 9'd5: csync_next = ~se;
                default:          csync_next = ~eq;
            endcase
        end
    end

    always_ff @(posedge clk_dot4x)
    begin
        if (rst)
        begin
            hsync <= 1'b0;
            csync <= 1'b0;
        end
        else
        begin
            hsync <= hsync_next;
            csync <= csync_next;  // one cycle behind raster
        end
    end

    // outside the hsync/back porch window and outside vertical blanking
    assign composite_active = ((raster.x < timing.hsync_start) ||
                               (raster.x > timing.hvisible_start)) &&
                              ((raster.y < timing.vblank_start) ||
                               (raster.y > timing.vblank_end));

    // colour clock divided by four
    always_ff @(posedge clk_col4x)
    begin
        if (rst)
            col_div <= 2'd0;
        else
            col_div <= col_div + 2'd1;
    end

    assign clk_colref = col_div[1];

endmodule

// ==== verilog/video_sync_top.sv ====
module video_sync_top #(
    parameter int DOT_DIV = 4
) (
    input  logic                  clk_dot4x,
    input  logic                  clk_col4x,
    input  logic                  rst,
    input  vic_pkg::chip_t        chip,
    output sync_pkg::raster_pos_t raster,
    output logic                  csync,
    output logic                  composite_active,
    output logic                  clk_colref
);

    sync_pkg::sync_timing_t timing;
    logic                   eq;
    logic                   se;

    assign timing = vic_pkg::sync_timing(chip);  // per-chip constants

    raster_counter #(
        .DOT_DIV (DOT_DIV)
    ) u_raster (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .raster    (raster)
    );

    eq_serr_pulse u_pulse (
        .raster (raster),
        .timing (timing),
        .eq     (eq),
        .se     (se)
    );

    comp_sync u_sync (
        .clk_dot4x        (clk_dot4x),
        .clk_col4x        (clk_col4x),
        .rst              (rst),
        .raster           (raster),
        .timing           (timing),
        .eq               (eq),
        .se               (se),
        .csync            (csync),
        .composite_active (composite_active),
        .clk_colref       (clk_colref)
    );

endmodule

// ==== tb/sync_chk.sv ====
module sync_chk (
    input logic                   clk_dot4x,
    input logic                   clk_col4x,
    input logic                   rst,
    input sync_pkg::raster_pos_t  raster,
    input sync_pkg::sync_timing_t timing,
    input logic                   csync,
    input logic                   hsync,
    input logic                   in_vsync,
    input logic                   clk_colref
);

    logic hs_window;   // x within hsync_start..hsync_end

    assign hs_window = (raster.x >= timing.hsync_start) &&
                       (raster.x <= timing.hsync_end);

    // reset edge clears the csync register
    csync_low_after_reset: assert property (
        @(posedge clk_dot4x) $past(rst) |-> !csync
    ) else $error("csync is not low in the cycle after reset");

    // a toggle is always followed by one quiet edge
    colref_every_second_edge: assert property (
        @(posedge clk_col4x) disable iff (rst)
        $changed(clk_colref) |=> $stable(clk_colref)
    ) else $error("clk_colref toggled on two edges in a row");

    // hsync follows the window of the previous dot, csync is its inverse
    normal_line_csync: assert property (
        @(posedge clk_dot4x)
        (!rst && $past(!rst && !in_vsync)) |->
            ((hsync == $past(hs_window)) && (csync == !hsync))
    ) else $error("csync is not the inverse of hsync on a normal line");

endmodule

bind comp_sync sync_chk chk0 (
    .clk_dot4x  (clk_dot4x),
    .clk_col4x  (clk_col4x),
    .rst        (rst),
    .raster     (raster),
    .timing     (timing),
    .csync      (csync),
    .hsync      (hsync),
    .in_vsync   (in_vsync),
    .clk_colref (clk_colref)
);

// ==== tb/tb_video_sync.sv ====
module tb_video_sync;

    localparam int DOT_DIV  = 1;
    localparam int EPISODES = 4;

    logic                  clk_dot4x;
    logic                  clk_col4x;
    logic                  rst;
    vic_pkg::chip_t        chip;
    sync_pkg::raster_pos_t raster;
    logic                  csync;
    logic                  composite_active;
    logic                  clk_colref;

    integer seed;
    int     errors;
    int     col_edges;     // clk_col4x cycles since the last colref toggle
    logic   colref_last;
    logic   colref_seen;

    video_sync_top #(
        .DOT_DIV (DOT_DIV)
    ) dut0 (
        .clk_dot4x        (clk_dot4x),
        .clk_col4x        (clk_col4x),
        .rst              (rst),
        .chip             (chip),
        .raster           (raster),
        .csync            (csync),
        .composite_active (composite_active),
        .clk_colref       (clk_colref)
    );

    always #10 clk_dot4x = ~clk_dot4x;
    always #7 clk_col4x = ~clk_col4x;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("FAIL %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // true when x lies in a window of width dots from start, wrapping at len
    function automatic logic in_window(input int x, input int start, input int width,
                                       input int len);
        int d;
        d = (x - start + len) % len;
        return d < width;
    endfunction

    function automatic logic expect_csync(input int x, input int y,
                                          input vic_pkg::chip_t model);
        sync_pkg::sync_timing_t t;
        int   len;
        int   half;
        int   start;
        int   second;
        int   se_w;
        int   ofs;
        logic eq;
        logic se;
        logic hs;

        t      = vic_pkg::sync_timing(model);
        len    = int'(vic_pkg::line_len(model));
        half   = len / 2;
        start  = int'(t.hsync_start);
        second = (start + half) % len;   // pulse of the second half line
        se_w   = half - int'(t.serr_width);
        eq = in_window(x, start, int'(t.eq_width), len) ||
             in_window(x, second, int'(t.eq_width), len);
        se = in_window(x, start, se_w, len) || in_window(x, second, se_w, len);
        hs = (x >= start) && (x <= int'(t.hsync_end));
        ofs = y - int'(t.vblank_start);
        if (ofs >= 3 && ofs <= 5)
            return !se;
        else if (ofs >= 0 && ofs <= 8)
            return !eq;
        return !hs;
    endfunction

    function automatic logic expect_active(input int x, input int y,
                                           input vic_pkg::chip_t model);
        sync_pkg::sync_timing_t t;

        t = vic_pkg::sync_timing(model);
        return (x < int'(t.hsync_start) || x > int'(t.hvisible_start)) &&
               (y < int'(t.vblank_start) || y > int'(t.vblank_end));
    endfunction

    // reset under a random chip, then one frame and a bit
    task automatic run_episode(input int num);
        vic_pkg::chip_t model;
        logic [31:0]    rnd;
        int             len;
        int             lines;
        int             total;
        int             mx;
        int             my;
        int             div;
        int             i;
        logic           exp_cs;

        rnd   = $random(seed);
        model = vic_pkg::chip_t'(rnd[1:0]);
        @(posedge clk_dot4x);
        rst  <= 1'b1;
        chip <= model;
        repeat (3) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        compare("clk_colref", 0, clk_colref);  // divider held in reset
        @(posedge clk_dot4x);
        rst <= 1'b0;

        len   = int'(vic_pkg::line_len(model));
        lines = int'(vic_pkg::frame_lines(model));
        total = len * lines * DOT_DIV + 100;
        $display("episode %0d: chip code %0d, %0d cycles", num, model, total);
        mx     = 0;
        my     = 0;
        div    = 0;
        exp_cs = 1'b0;   // csync still from the reset edge
        for (i = 0; i < total; i++)
        begin
            @(negedge clk_dot4x);
            compare("raster.x", mx, raster.x);
            compare("raster.y", my, raster.y);
            compare("csync", exp_cs, csync);
            compare("composite_active", expect_active(mx, my, model), composite_active);
            exp_cs = expect_csync(mx, my, model);   // shows up one cycle later
            div++;
            if (div == DOT_DIV)
            begin
                div = 0;
                if (mx == len - 1)
                begin
                    mx = 0;
                    my = (my == lines - 1) ? 0 : my + 1;
                end
                else
                begin
                    mx++;
                end
            end
        end
    endtask

    // colour reference must toggle every second clk_col4x cycle
    always @(negedge clk_col4x)
    begin
        if (rst)
        begin
            col_edges   = 0;
            colref_last = clk_colref;
            colref_seen = 1'b0;
        end
        else
        begin
            col_edges++;
            if (clk_colref !== colref_last)
            begin
                if (colref_seen)
                    compare("clk_colref edges", 2, col_edges);
                col_edges   = 0;
                colref_seen = 1'b1;
                colref_last = clk_colref;
            end
            else if (col_edges == 4)
            begin
                compare("clk_colref edges", 2, col_edges);  // stuck divider
            end
        end
    end

    initial
    begin
        int ep;

        clk_dot4x   = 1'b0;
        clk_col4x   = 1'b0;
        rst         = 1'b1;
        chip        = vic_pkg::CHIP6569;
        seed        = 99;
        errors      = 0;
        col_edges   = 0;
        colref_last = 1'b0;
        colref_seen = 1'b0;
        for (ep = 0; ep < EPISODES; ep++)
            run_episode(ep);
        $display("checks failed: %0d", errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the longest frame of any chip code
    initial
    begin
        longint frame_max;
        longint cycles;
        int     c;

        frame_max = 0;
        for (c = 0; c < 4; c++)
        begin
            cycles = longint'(vic_pkg::line_len(vic_pkg::chip_t'(c))) *
                     longint'(vic_pkg::frame_lines(vic_pkg::chip_t'(c))) * DOT_DIV;
            if (cycles > frame_max)
                frame_max = cycles;
        end
        #(EPISODES * (frame_max + 200) * 20 * 2);
        $display("timeout: the episodes did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/sync_pkg.sv
verilog/vic_pkg.sv
verilog/raster_counter.sv
verilog/eq_serr_pulse.sv
verilog/comp_sync.sv
verilog/video_sync_top.sv
tb/sync_chk.sv
tb/tb_video_sync.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_video_sync -f sources.f

output=$(./obj_dir/Vtb_video_sync)
echo "$output"
echo "$output" | grep -q "RESULT: PASS"
